//--- verilog.f
+incdir+testbench
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/port_arbiter.sv
verilog/cache_array.sv
verilog/cache_controller.sv
verilog/backing_memory.sv
verilog/dcache_top.sv
testbench/tb_dcache.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP := tb_dcache

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv testbench/*.sv testbench/*.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only -Wall --timing --top-module dcache_top -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- testbench/cache_model.svh
// reference model of cache tags and memory image
`ifndef cache_model_svh
`define cache_model_svh

logic [word_w-1:0] model_mem [2 ** addr_w];
int                model_tag [line_count];
logic              model_valid [line_count];

function automatic void model_reset();
    for (int i = 0; i < 2 ** addr_w; i++) begin
        model_mem[i] = '0;
    end
    for (int i = 0; i < line_count; i++) begin
        model_valid[i] = 1'b0;
        model_tag[i] = 0;
    end
endfunction

// applied once per ack, in ack order
function automatic void model_access(input logic is_write, input logic [addr_w-1:0] addr,
                                     input logic [word_w-1:0] wdata, output logic exp_hit,
                                     output logic [word_w-1:0] exp_data);
    int idx;
    int tag;
    idx = (int'(addr) >> offset_w) % line_count;
    tag = int'(addr) >> (offset_w + index_w);
    exp_hit = model_valid[idx] && (model_tag[idx] == tag);
    if (is_write) begin
        model_mem[addr] = wdata;
        exp_data = wdata;
    end else begin
        exp_data = model_mem[addr];
    end
    // line holds this tag after a hit or a refill
    model_valid[idx] = 1'b1;
    model_tag[idx] = tag;
endfunction

`endif

//--- testbench/tb_dcache.sv
// four-port data cache testbench

module tb_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;
    import bus_pkg::*;

    localparam int line_count = 16;
    localparam int index_w    = $clog2(line_count);
    localparam int total_acc  = 2000;
    // a dirty miss plus arbitration stays well under 80 cycles
    localparam int max_cycles = total_acc * 80;

    logic    clk;
    logic    rst;
    wb_req_t port_req [4];
    wb_rsp_t rd0_rsp;
    wb_rsp_t rd1_rsp;
    wb_rsp_t rd2_rsp;
    wb_rsp_t wr_rsp;
    logic    active [4];
    int      gap [4];
    int      issued;
    int      acked;
    int      cycles;

    `include "cache_model.svh"

    dcache_top #(.line_count(line_count)) dut (
        .clk, .rst,
        .rd0_req(port_req[0]), .rd1_req(port_req[1]),
        .rd2_req(port_req[2]), .wr_req(port_req[3]),
        .rd0_rsp, .rd1_rsp, .rd2_rsp, .wr_rsp
    );

    always #10 clk = ~clk;

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [word_w-1:0] expected,
                               input logic [word_w-1:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            fail_run();
        end
    endtask

    // one clock edge of all four port masters
    task automatic serve_ports();
        wb_rsp_t           rsp [4];
        logic              exp_hit;
        logic [word_w-1:0] exp_data;
        logic [addr_w-1:0] addr;
        logic              we_bit;
        int                ack_count;
        rsp[0] = rd0_rsp;
        rsp[1] = rd1_rsp;
        rsp[2] = rd2_rsp;
        rsp[3] = wr_rsp;
        ack_count = 0;
        for (int p = 0; p < 4; p++) begin
            if (rsp[p].ack) begin
                ack_count++;
                assert (active[p]) else begin
                    $display("ack on port %0d at %0t ns without a held request", p, $time);
                    fail_run();
                end
                model_access(p == 3, port_req[p].adr, port_req[p].dat_w, exp_hit, exp_data);
                check_value($sformatf("port %0d dat_r", p), exp_data, rsp[p].dat_r);
                check_value($sformatf("port %0d hit", p), word_w'(exp_hit), word_w'(rsp[p].hit));
                port_req[p] <= '0;
                active[p] = 1'b0;
                gap[p] = $urandom_range(0, 3);
                acked++;
            end else if (!active[p] && issued < total_acc) begin
                if (gap[p] > 0) begin
                    gap[p]--;
                end else begin
                    // four tags over four indices, so lines collide often
                    addr = addr_w'(($urandom_range(0, 3) << (offset_w + index_w))
                                   | ($urandom_range(0, 3) << offset_w));
                    addr = addr | addr_w'($urandom_range(0, line_words - 1));
                    // read ports set we at random and must still read
                    we_bit = (p == 3) || ($urandom_range(0, 1) == 1);
                    port_req[p] <= '{cyc: 1'b1, stb: 1'b1, we: we_bit, adr: addr,
                                     dat_w: $urandom()};
                    active[p] = 1'b1;
                    issued++;
                end
            end
        end
        assert (ack_count <= 1) else begin
            $display("%0d acks arrived in one cycle at %0t ns", ack_count, $time);
            fail_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        issued = 0;
        acked = 0;
        cycles = 0;
        for (int p = 0; p < 4; p++) begin
            port_req[p] = '0;
            active[p] = 1'b0;
            gap[p] = 0;
        end
        void'($urandom(14));
        model_reset();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // zero gaps make all four ports request together first
        while (acked < total_acc) begin
            @(posedge clk);
            serve_ports();
        end
        $display("Done: no errors");
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d accesses acked",
                     cycles, acked, total_acc);
            fail_run();
        end
    end

endmodule

//--- verilog/dcache_top.sv
// data cache with four wishbone ports and backing memory

module dcache_top #(
    parameter  int line_count = 16,
    localparam int index_w    = $clog2(line_count),
    localparam int tag_w      = cache_pkg::addr_w - cache_pkg::offset_w - index_w
) (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t rd0_req,
    input  bus_pkg::wb_req_t rd1_req,
    input  bus_pkg::wb_req_t rd2_req,
    input  bus_pkg::wb_req_t wr_req,
    output bus_pkg::wb_rsp_t rd0_rsp,
    output bus_pkg::wb_rsp_t rd1_rsp,
    output bus_pkg::wb_rsp_t rd2_rsp,
    output bus_pkg::wb_rsp_t wr_rsp
);

    import cache_pkg::*;
    import bus_pkg::*;

    access_t                           acc;
    logic                              acc_valid;
    logic                              done;
    logic                              hit;
    logic [word_w-1:0]                 rdata;
    wb_req_t                           mem_req;
    wb_rsp_t                           mem_rsp;

    logic [index_w-1:0]                index;
    logic                              line_we;
    logic [line_words-1:0][word_w-1:0] line_wdata;
    logic [tag_w-1:0]                  line_tag;
    logic                              line_dirty;
    logic                              word_we;
    logic [offset_w-1:0]               word_offset;
    logic [word_w-1:0]                 word_wdata;
    logic [line_words-1:0][word_w-1:0] line_rdata;
    logic [tag_w-1:0]                  tag_q;
    logic                              valid_q;
    logic                              dirty_q;

    port_arbiter u_arbiter (
        .clk, .rst,
        .rd0_req, .rd1_req, .rd2_req, .wr_req,
        .rd0_rsp, .rd1_rsp, .rd2_rsp, .wr_rsp,
        .acc, .acc_valid, .done, .hit, .rdata
    );

    cache_controller #(.line_count(line_count)) u_controller (
        .clk, .rst,
        .acc, .acc_valid, .done, .hit, .rdata,
        .mem_req, .mem_rsp,
        .index, .line_we, .line_wdata, .line_tag, .line_dirty,
        .word_we, .word_offset, .word_wdata,
        .line_rdata, .tag_q, .valid_q, .dirty_q
    );

    cache_array #(.line_count(line_count)) u_array (
        .clk, .rst,
        .index, .line_we, .line_wdata, .line_tag, .line_dirty,
        .word_we, .word_offset, .word_wdata,
        .line_rdata, .tag_q, .valid_q, .dirty_q
    );

    // memory sits beside the cache under the top
    backing_memory u_memory (
        .clk, .rst,
        .req(mem_req),
        .rsp(mem_rsp)
    );

endmodule

//--- verilog/backing_memory.sv
// word memory, wishbone classic slave with one wait state

module backing_memory (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t req,
    output bus_pkg::wb_rsp_t rsp
);

    import cache_pkg::*;

    localparam int depth = 2 ** addr_w;

    logic [word_w-1:0] mem [depth];
    logic              ack_q;
    logic [word_w-1:0] dat_q;
    logic              start;

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // a held request is served again after its ack
    assign start = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start && req.we) begin
            mem[req.adr] <= req.dat_w;
        end
        dat_q <= mem[req.adr];
    end

    assign rsp = '{ack: ack_q, dat_r: dat_q, hit: 1'b0};

endmodule

//--- verilog/cache_controller.sv
// write-back, write-allocate cache controller
// lookup, victim write-back and line refill over wishbone

module cache_controller #(
    parameter  int line_count = 16,
    localparam int index_w    = $clog2(line_count),
    localparam int tag_w      = cache_pkg::addr_w - cache_pkg::offset_w - index_w
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  cache_pkg::access_t                                     acc,
    input  logic                                                   acc_valid,
    output logic                                                   done,
    output logic                                                   hit,
    output logic [cache_pkg::word_w-1:0]                           rdata,
    output bus_pkg::wb_req_t                                       mem_req,
    input  bus_pkg::wb_rsp_t                                       mem_rsp,
    output logic [index_w-1:0]                                     index,
    output logic                                                   line_we,
    output logic [cache_pkg::line_words-1:0][cache_pkg::word_w-1:0] line_wdata,
    output logic [tag_w-1:0]                                       line_tag,
    output logic                                                   line_dirty,
    output logic                                                   word_we,
    output logic [cache_pkg::offset_w-1:0]                         word_offset,
    output logic [cache_pkg::word_w-1:0]                           word_wdata,
    input  logic [cache_pkg::line_words-1:0][cache_pkg::word_w-1:0] line_rdata,
    input  logic [tag_w-1:0]                                       tag_q,
    input  logic                                                   valid_q,
    input  logic                                                   dirty_q
);

    import cache_pkg::*;

    localparam logic [offset_w-1:0] last_word = offset_w'(line_words - 1);

    ctrl_state_t                       state;
    ctrl_state_t                       state_next;
    logic [offset_w-1:0]               word_cnt;
    logic                              missed;
    logic [line_words-1:0][word_w-1:0] fill_buf;
    logic [line_words-1:0][word_w-1:0] fill_line;
    logic [offset_w-1:0]               acc_offset;
    logic [tag_w-1:0]                  acc_tag;
    logic                              tag_match;
    logic                              bus_active;
    logic                              last_ack;

    // address fields
    assign acc_offset = acc.addr[offset_w-1:0];
    assign index      = acc.addr[offset_w +: index_w];
    assign acc_tag    = acc.addr[addr_w-1 -: tag_w];

    assign tag_match  = valid_q && (tag_q == acc_tag);
    assign bus_active = (state == st_writeback) || (state == st_refill);
    assign last_ack   = mem_rsp.ack && (word_cnt == last_word);

    always_comb begin
        state_next = state;
        case (state)
            st_idle:
                if (acc_valid) state_next = st_lookup;
            st_lookup:
                if (tag_match) state_next = st_respond;
                else if (dirty_q) state_next = st_writeback;
                else state_next = st_refill;
            st_writeback:
                if (last_ack) state_next = st_refill;
            // after refill the lookup hits on the new line
            st_refill:
                if (last_ack) state_next = st_lookup;
            st_respond:
                state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            word_cnt <= '0;
            missed <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_idle) begin
                missed <= 1'b0;
            end else if (state == st_lookup && !tag_match) begin
                missed <= 1'b1;
            end
            // wraps to zero between write-back and refill
            if (bus_active && mem_rsp.ack) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_refill && mem_rsp.ack) begin
            fill_buf[word_cnt] <= mem_rsp.dat_r;
        end
    end

    // last word goes straight from the bus into the line
    always_comb begin
        fill_line = fill_buf;
        fill_line[word_cnt] = mem_rsp.dat_r;
    end

    assign line_we    = (state == st_refill) && last_ack;
    assign line_wdata = fill_line;
    assign line_tag   = acc_tag;
    assign line_dirty = 1'b0;

    assign word_we     = (state == st_lookup) && tag_match && (acc.op == op_write);
    assign word_offset = acc_offset;
    assign word_wdata  = acc.data;

    // memory master, one word per cycle
    always_comb begin
        mem_req.cyc   = bus_active;
        mem_req.stb   = bus_active;
        mem_req.we    = (state == st_writeback);
        mem_req.adr   = {(state == st_writeback) ? tag_q : acc_tag, index, word_cnt};
        mem_req.dat_w = line_rdata[word_cnt];
    end

    assign done  = (state == st_respond);
    assign hit   = !missed;
    // writes echo the stored word
    assign rdata = (acc.op == op_write) ? acc.data : line_rdata[acc_offset];

endmodule

//--- verilog/cache_array.sv
// direct-mapped line, tag, valid and dirty storage

module cache_array #(
    parameter  int line_count = 16,
    localparam int index_w    = $clog2(line_count),
    localparam int tag_w      = cache_pkg::addr_w - cache_pkg::offset_w - index_w
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [index_w-1:0]                                     index,
    input  logic                                                   line_we,
    input  logic [cache_pkg::line_words-1:0][cache_pkg::word_w-1:0] line_wdata,
    input  logic [tag_w-1:0]                                       line_tag,
    input  logic                                                   line_dirty,
    input  logic                                                   word_we,
    input  logic [cache_pkg::offset_w-1:0]                         word_offset,
    input  logic [cache_pkg::word_w-1:0]                           word_wdata,
    output logic [cache_pkg::line_words-1:0][cache_pkg::word_w-1:0] line_rdata,
    output logic [tag_w-1:0]                                       tag_q,
    output logic                                                   valid_q,
    output logic                                                   dirty_q
);

    import cache_pkg::*;

    logic [line_words-1:0][word_w-1:0] data_mem [line_count];
    logic [tag_w-1:0]                  tag_mem  [line_count];
    logic [line_count-1:0]             valid_mem;
    logic [line_count-1:0]             dirty_mem;

    // line and tag contents
    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[index] <= line_wdata;
            tag_mem[index] <= line_tag;
        end else if (word_we) begin
            data_mem[index][word_offset] <= word_wdata;
        end
    end

    // status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else if (line_we) begin
            valid_mem[index] <= 1'b1;
            dirty_mem[index] <= line_dirty;
        end else if (word_we) begin
            dirty_mem[index] <= 1'b1;
        end
    end

    // combinational read of the indexed line
    assign line_rdata = data_mem[index];
    assign tag_q      = tag_mem[index];
    assign valid_q    = valid_mem[index];
    assign dirty_q    = dirty_mem[index];

endmodule

//--- verilog/port_arbiter.sv
// round-robin arbiter for three read ports and one write port

module port_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  bus_pkg::wb_req_t              rd0_req,
    input  bus_pkg::wb_req_t              rd1_req,
    input  bus_pkg::wb_req_t              rd2_req,
    input  bus_pkg::wb_req_t              wr_req,
    output bus_pkg::wb_rsp_t              rd0_rsp,
    output bus_pkg::wb_rsp_t              rd1_rsp,
    output bus_pkg::wb_rsp_t              rd2_rsp,
    output bus_pkg::wb_rsp_t              wr_rsp,
    output cache_pkg::access_t            acc,
    output logic                          acc_valid,
    input  logic                          done,
    input  logic                          hit,
    input  logic [cache_pkg::word_w-1:0]  rdata
);

    import cache_pkg::*;
    import bus_pkg::*;

    wb_req_t    port_req [4];
    logic [3:0] req_vec;
    logic [3:0] ack_vec;
    logic       busy;
    logic [1:0] grant_idx;
    logic [1:0] last_idx;
    logic [1:0] next_idx;
    logic [1:0] cand;
    logic       found;

    // port 3 is the write port
    assign port_req[0] = rd0_req;
    assign port_req[1] = rd1_req;
    assign port_req[2] = rd2_req;
    assign port_req[3] = wr_req;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            req_vec[i] = port_req[i].cyc & port_req[i].stb;
        end
    end

    // search starts just after the last winner
    always_comb begin
        next_idx = last_idx;
        found = 1'b0;
        cand = last_idx;
        for (int k = 1; k <= 4; k++) begin
            cand = last_idx + 2'(k);
            if (!found && req_vec[cand]) begin
                next_idx = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            grant_idx <= 2'd0;
            last_idx <= 2'd3;
        end else if (busy) begin
            if (done) begin
                busy <= 1'b0;
                last_idx <= grant_idx;
            end
        end else if (found) begin
            busy <= 1'b1;
            grant_idx <= next_idx;
        end
    end

    // we on a read port is ignored
    always_comb begin
        acc.op = (grant_idx == 2'd3) ? op_write : op_read;
        acc.addr = port_req[grant_idx].adr;
        acc.data = port_req[grant_idx].dat_w;
    end

    assign acc_valid = busy;

    // ack only to the winner
    assign ack_vec = (busy && done) ? (4'b0001 << grant_idx) : 4'b0000;

    assign rd0_rsp = '{ack: ack_vec[0], dat_r: rdata, hit: hit};
    assign rd1_rsp = '{ack: ack_vec[1], dat_r: rdata, hit: hit};
    assign rd2_rsp = '{ack: ack_vec[2], dat_r: rdata, hit: hit};
    assign wr_rsp  = '{ack: ack_vec[3], dat_r: rdata, hit: hit};

endmodule

//--- verilog/bus_pkg.sv
// wishbone classic bus types

package bus_pkg;

    // client ports and memory bus share this request shape
    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [cache_pkg::addr_w-1:0]  adr;
        logic [cache_pkg::word_w-1:0]  dat_w;
    } wb_req_t;

    // hit is only meaningful on client ports
    typedef struct packed {
        logic                          ack;
        logic [cache_pkg::word_w-1:0]  dat_r;
        logic                          hit;
    } wb_rsp_t;

endpackage

//--- verilog/cache_pkg.sv
// data cache geometry and access types

package cache_pkg;

    // word-addressed backing store
    localparam int word_w = 32;
    localparam int addr_w = 12;

    // 16 words per line
    localparam int offset_w = 4;
    localparam int line_words = 16;

    typedef enum logic {
        op_read,
        op_write
    } access_op_t;

    // single admitted access, arbiter to controller
    typedef struct packed {
        access_op_t        op;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;
    } access_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_respond
    } ctrl_state_t;

endpackage
